//--- Makefile
# run from the project root, the testbench opens sim/fifo_if_vectors.txt
sim:
	verilator --binary --timing --assert --top-module fifo_if_tb -f flist.f -o fifo_if_sim
	./obj_dir/fifo_if_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- design/axil_fifo_regs.sv
module axil_fifo_regs #(
    parameter int FIFO_AW      = 4,
    parameter int GRP_SIZE     = 8,
    parameter int TXD_REV_TYPE = fifo_if_pkg::rev_groups,
    parameter int RXD_REV_TYPE = fifo_if_pkg::rev_none
) (
    input  logic                              clk,
    input  logic                              rst,
    // aw
    input  logic [fifo_if_pkg::axi_aw-1:0]    s_axi_awaddr,
    input  logic [2:0]                        s_axi_awprot,
    input  logic                              s_axi_awvalid,
    output logic                              s_axi_awready,
    // w
    input  logic [fifo_if_pkg::axi_dw-1:0]    s_axi_wdata,
    input  logic [fifo_if_pkg::axi_dw/8-1:0]  s_axi_wstrb,
    input  logic                              s_axi_wvalid,
    output logic                              s_axi_wready,
    // b
    output logic [1:0]                        s_axi_bresp,
    output logic                              s_axi_bvalid,
    input  logic                              s_axi_bready,
    // ar
    input  logic [fifo_if_pkg::axi_aw-1:0]    s_axi_araddr,
    input  logic [2:0]                        s_axi_arprot,
    input  logic                              s_axi_arvalid,
    output logic                              s_axi_arready,
    // r
    output logic [fifo_if_pkg::axi_dw-1:0]    s_axi_rdata,
    output logic [1:0]                        s_axi_rresp,
    output logic                              s_axi_rvalid,
    input  logic                              s_axi_rready,
    // fifo side
    output logic                              tx_push,
    output logic [fifo_if_pkg::axi_dw-1:0]    tx_din,
    output logic                              tx_clr,
    output logic                              rx_pop,
    output logic                              rx_clr,
    input  logic [fifo_if_pkg::axi_dw-1:0]    rx_head,
    input  fifo_if_pkg::fifo_status_t         tx_status,
    input  fifo_if_pkg::fifo_status_t         rx_status,
    output logic                              intr
);

    localparam int dw = fifo_if_pkg::axi_dw;

    logic [3:0]             waddr;
    logic [3:0]             raddr;
    logic                   wr_hs;
    logic                   rd_hs;
    logic [FIFO_AW:0]       rxf_th;
    logic [FIFO_AW:0]       txe_th;
    logic [FIFO_AW:0]       rx_cnt;
    logic [FIFO_AW:0]       tx_cnt;
    fifo_if_pkg::irq_bits_t ie;
    fifo_if_pkg::irq_bits_t is;
    logic [dw-1:0]          rd_value;

    function automatic logic [dw-1:0] reorder(input logic [dw-1:0] word, input int rev_type);
        logic [dw-1:0] bits_rev;
        bits_rev = {<<{word}};
        case (rev_type)
            fifo_if_pkg::rev_groups:   reorder = {<<GRP_SIZE{word}};
            fifo_if_pkg::rev_in_group: reorder = {<<GRP_SIZE{bits_rev}};  // groups back in place
            default:                   reorder = word;
        endcase
    endfunction

    assign s_axi_awready = 1'b1;
    assign s_axi_bresp   = 2'b00;  // always okay
    assign s_axi_rresp   = 2'b00;

    assign wr_hs = s_axi_wvalid & s_axi_wready;
    assign rd_hs = s_axi_arvalid & s_axi_arready;
    assign raddr = s_axi_araddr[5:2];

    // write address, awready always high
    always_ff @(posedge clk) begin
        if (rst) waddr <= '0;
        else if (s_axi_awvalid) waddr <= s_axi_awaddr[5:2];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_axi_wready <= 1'b0;
        end else if (wr_hs) begin
            s_axi_wready <= 1'b0;
        end else if (s_axi_awvalid && !s_axi_bvalid) begin
            s_axi_wready <= 1'b1;  // address seen
        end
    end

    always_ff @(posedge clk) begin
        if (rst) s_axi_bvalid <= 1'b0;
        else if (wr_hs) s_axi_bvalid <= 1'b1;
        else if (s_axi_bready) s_axi_bvalid <= 1'b0;
    end

    // no new read address while a response is pending
    always_ff @(posedge clk) begin
        if (rst) begin
            s_axi_arready <= 1'b0;
        end else if (rd_hs) begin
            s_axi_arready <= 1'b0;
        end else if (s_axi_arvalid && !s_axi_rvalid) begin
            s_axi_arready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) s_axi_rvalid <= 1'b0;
        else if (rd_hs) s_axi_rvalid <= 1'b1;
        else if (s_axi_rready) s_axi_rvalid <= 1'b0;
    end

    assign rx_cnt = rx_status.count[FIFO_AW:0];
    assign tx_cnt = tx_status.count[FIFO_AW:0];

    always_comb begin
        case (raddr)
            fifo_if_pkg::reg_data:   rd_value = reorder(rx_head, RXD_REV_TYPE);
            fifo_if_pkg::reg_rx_cnt: rd_value = dw'(rx_status.count);
            fifo_if_pkg::reg_tx_cnt: rd_value = dw'(tx_status.count);
            fifo_if_pkg::reg_rxf_th: rd_value = dw'(rxf_th);
            fifo_if_pkg::reg_txe_th: rd_value = dw'(txe_th);
            fifo_if_pkg::reg_ie:     rd_value = {{(dw-2){1'b0}}, ie};
            fifo_if_pkg::reg_is:     rd_value = {{(dw-2){1'b0}}, is};
            default:                 rd_value = '0;
        endcase
    end

    // captured at the handshake, held through rready
    always_ff @(posedge clk) begin
        if (rd_hs) s_axi_rdata <= rd_value;
    end

    assign rx_pop  = rd_hs && (raddr == fifo_if_pkg::reg_data);
    assign tx_push = wr_hs && (waddr == fifo_if_pkg::reg_data);
    assign tx_din  = reorder(s_axi_wdata, TXD_REV_TYPE);
    assign rx_clr  = wr_hs && (waddr == fifo_if_pkg::reg_rx_cnt);
    assign tx_clr  = wr_hs && (waddr == fifo_if_pkg::reg_tx_cnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            rxf_th <= (FIFO_AW+1)'(1) << (FIFO_AW-1);  // half depth
            txe_th <= (FIFO_AW+1)'(1) << (FIFO_AW-1);
            ie     <= '0;
        end else if (wr_hs) begin
            case (waddr)
                fifo_if_pkg::reg_rxf_th: rxf_th <= s_axi_wdata[FIFO_AW:0];
                fifo_if_pkg::reg_txe_th: txe_th <= s_axi_wdata[FIFO_AW:0];
                fifo_if_pkg::reg_ie:     ie     <= s_axi_wdata[1:0];
                default: ;
            endcase
        end
    end

    assign is.rxf = (rx_cnt >= rxf_th) || rx_status.full;
    assign is.txe = (tx_cnt <= txe_th);

    always_ff @(posedge clk) begin
        if (rst) intr <= 1'b0;
        else intr <= |(ie & is);
    end

endmodule

//--- design/fifo_if_pkg.sv
package fifo_if_pkg;

    // bus geometry
    localparam int axi_dw = 32;
    localparam int axi_aw = 6;  // byte address, word index in bits 5:2

    // register word indices
    localparam logic [3:0] reg_data   = 4'd0;  // rd pops rx, wr pushes tx
    localparam logic [3:0] reg_rx_cnt = 4'd1;  // wr clears rx
    localparam logic [3:0] reg_tx_cnt = 4'd2;  // wr clears tx
    localparam logic [3:0] reg_rxf_th = 4'd3;
    localparam logic [3:0] reg_txe_th = 4'd4;
    localparam logic [3:0] reg_ie     = 4'd8;
    localparam logic [3:0] reg_is     = 4'd9;

    // widest count any fifo reports
    localparam int cnt_w = 16;

    // word reorder kinds
    localparam int rev_none     = 0;
    localparam int rev_groups   = 1;  // group order reversed
    localparam int rev_in_group = 2;  // bits reversed inside each group

    typedef struct packed {
        logic [cnt_w-1:0] count;  // zero extended
        logic             full;
        logic             empty;
    } fifo_status_t;

    // bit 1 txe, bit 0 rxf
    typedef struct packed {
        logic txe;
        logic rxf;
    } irq_bits_t;

endpackage

//--- design/fifo_if_top.sv
module fifo_if_top #(
    parameter int FIFO_AW      = 4,
    parameter int GRP_SIZE     = 8,
    parameter int TXD_REV_TYPE = fifo_if_pkg::rev_groups,
    parameter int RXD_REV_TYPE = fifo_if_pkg::rev_none
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [fifo_if_pkg::axi_aw-1:0]    s_axi_awaddr,
    input  logic [2:0]                        s_axi_awprot,
    input  logic                              s_axi_awvalid,
    output logic                              s_axi_awready,
    input  logic [fifo_if_pkg::axi_dw-1:0]    s_axi_wdata,
    input  logic [fifo_if_pkg::axi_dw/8-1:0]  s_axi_wstrb,
    input  logic                              s_axi_wvalid,
    output logic                              s_axi_wready,
    output logic [1:0]                        s_axi_bresp,
    output logic                              s_axi_bvalid,
    input  logic                              s_axi_bready,
    input  logic [fifo_if_pkg::axi_aw-1:0]    s_axi_araddr,
    input  logic [2:0]                        s_axi_arprot,
    input  logic                              s_axi_arvalid,
    output logic                              s_axi_arready,
    output logic [fifo_if_pkg::axi_dw-1:0]    s_axi_rdata,
    output logic [1:0]                        s_axi_rresp,
    output logic                              s_axi_rvalid,
    input  logic                              s_axi_rready,
    output logic [fifo_if_pkg::axi_dw-1:0]    sink_data,
    output logic                              sink_strobe,
    input  logic                              sink_ready,
    input  logic [fifo_if_pkg::axi_dw-1:0]    source_data,
    input  logic                              source_strobe,
    output logic                              intr
);

    logic                             tx_push;
    logic                             tx_pop;
    logic                             tx_clr;
    logic [fifo_if_pkg::axi_dw-1:0]   tx_din;
    logic [fifo_if_pkg::axi_dw-1:0]   tx_head;
    fifo_if_pkg::fifo_status_t        tx_status;
    logic                             rx_push;
    logic                             rx_pop;
    logic                             rx_clr;
    logic [fifo_if_pkg::axi_dw-1:0]   rx_din;
    logic [fifo_if_pkg::axi_dw-1:0]   rx_head;
    fifo_if_pkg::fifo_status_t        rx_status;

    axil_fifo_regs #(
        .FIFO_AW      (FIFO_AW),
        .GRP_SIZE     (GRP_SIZE),
        .TXD_REV_TYPE (TXD_REV_TYPE),
        .RXD_REV_TYPE (RXD_REV_TYPE)
    ) regs_i (
        .clk, .rst,
        .s_axi_awaddr, .s_axi_awprot, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
        .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
        .s_axi_araddr, .s_axi_arprot, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
        .tx_push, .tx_din, .tx_clr,
        .rx_pop, .rx_clr, .rx_head,
        .tx_status, .rx_status,
        .intr
    );

    // bus writes in, stream reads out
    sync_fifo #(.FIFO_AW(FIFO_AW), .DW(fifo_if_pkg::axi_dw)) tx_fifo (
        .clk, .rst,
        .push (tx_push), .pop (tx_pop), .clr (tx_clr),
        .din (tx_din), .head (tx_head), .status (tx_status)
    );

    // stream writes in, bus reads out
    sync_fifo #(.FIFO_AW(FIFO_AW), .DW(fifo_if_pkg::axi_dw)) rx_fifo (
        .clk, .rst,
        .push (rx_push), .pop (rx_pop), .clr (rx_clr),
        .din (rx_din), .head (rx_head), .status (rx_status)
    );

    stream_port stream_i (
        .clk, .rst,
        .tx_head, .tx_status, .tx_pop,
        .sink_ready, .sink_data, .sink_strobe,
        .source_data, .source_strobe,
        .rx_push, .rx_din
    );

endmodule

//--- design/stream_port.sv
module stream_port (
    input  logic                              clk,
    input  logic                              rst,
    // tx fifo read side
    input  logic [fifo_if_pkg::axi_dw-1:0]    tx_head,
    input  fifo_if_pkg::fifo_status_t         tx_status,
    output logic                              tx_pop,
    // sink
    input  logic                              sink_ready,
    output logic [fifo_if_pkg::axi_dw-1:0]    sink_data,
    output logic                              sink_strobe,
    // source
    input  logic [fifo_if_pkg::axi_dw-1:0]    source_data,
    input  logic                              source_strobe,
    // rx fifo write side
    output logic                              rx_push,
    output logic [fifo_if_pkg::axi_dw-1:0]    rx_din
);

    // one word per cycle while the sink is ready
    assign tx_pop = sink_ready & ~tx_status.empty;

    always_ff @(posedge clk) begin
        if (rst) sink_strobe <= 1'b0;
        else sink_strobe <= tx_pop;
    end

    always_ff @(posedge clk) begin
        if (tx_pop) sink_data <= tx_head;  // held between words
    end

    // the rx fifo drops words once full
    assign rx_push = source_strobe;
    assign rx_din  = source_data;

endmodule

//--- design/sync_fifo.sv
module sync_fifo #(
    parameter int FIFO_AW = 4,
    parameter int DW      = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  logic                       pop,
    input  logic                       clr,
    input  logic [DW-1:0]              din,
    output logic [DW-1:0]              head,
    output fifo_if_pkg::fifo_status_t  status
);

    localparam int depth = 2 ** FIFO_AW;

    logic [DW-1:0]      mem [depth];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;   // one extra bit so depth fits
    logic               full;
    logic               empty;
    logic               do_push;
    logic               do_pop;

    assign full    = count[FIFO_AW];  // only reaches depth when full
    assign empty   = (count == '0);
    assign do_push = push & ~full;    // dropped when full
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push with pop
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    // first word falls through
    assign head = mem[rd_ptr];

    assign status.count = fifo_if_pkg::cnt_w'(count);
    assign status.full  = full;
    assign status.empty = empty;

endmodule

//--- flist.f
design/fifo_if_pkg.sv
design/sync_fifo.sv
design/axil_fifo_regs.sv
design/stream_port.sv
design/fifo_if_top.sv
sim/fifo_if_assertions.sv
sim/fifo_if_tb.sv

//--- sim/fifo_if_assertions.sv
module fifo_if_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   s_axi_rvalid,
    input logic                   s_axi_rready,
    input logic [31:0]            s_axi_rdata,
    input logic                   s_axi_bvalid,
    input logic                   s_axi_bready,
    input fifo_if_pkg::irq_bits_t ie,
    input logic                   intr
);

    // read response held with its data until taken
    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
        else $error("rvalid or rdata changed before rready");

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    // intr is registered, so the enable is one cycle older
    intr_enabled: assert property (@(posedge clk) disable iff (rst)
        intr |-> $past(ie) != '0)
        else $error("intr high with no enable bit set");

endmodule

bind axil_fifo_regs fifo_if_assertions assertions_i (
    .clk          (clk),
    .rst          (rst),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready),
    .s_axi_rdata  (s_axi_rdata),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bready (s_axi_bready),
    .ie           (ie),
    .intr         (intr)
);

//--- sim/fifo_if_tb.sv
module fifo_if_tb;

    localparam int wait_limit = 20;  // cycles per handshake wait

    logic        clk;
    logic        rst;
    logic [5:0]  s_axi_awaddr;
    logic [2:0]  s_axi_awprot;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [5:0]  s_axi_araddr;
    logic [2:0]  s_axi_arprot;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic [31:0] sink_data;
    logic        sink_strobe;
    logic        sink_ready;
    logic [31:0] source_data;
    logic        source_strobe;
    logic        intr;

    logic [31:0] sent_q[$];  // tx words not yet drained
    integer      seed;

    fifo_if_top fifo_if_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s: got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    // sink sees written words with byte order reversed
    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        swap_bytes = {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic axi_write(input logic [5:0] addr, input logic [31:0] data);
        int n;
        @(negedge clk);
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wvalid  = 1'b1;
        n = 0;
        while (!s_axi_awready) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) abort_run("write address was never accepted");
        end
        @(negedge clk);  // address taken on the edge just passed
        s_axi_awvalid = 1'b0;
        n = 0;
        while (!s_axi_wready) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) abort_run("wready never rose after the write address");
        end
        @(negedge clk);
        s_axi_wvalid = 1'b0;
        n = 0;
        while (!s_axi_bvalid) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) abort_run("no write response arrived");
        end
        check_value("s_axi_bresp", 32'(s_axi_bresp), 32'h0);  // okay
        @(negedge clk);  // one cycle of back-pressure on b
        s_axi_bready = 1'b1;
        @(negedge clk);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [5:0] addr, output logic [31:0] data);
        int n;
        @(negedge clk);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        n = 0;
        while (!s_axi_arready) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) abort_run("read address was never accepted");
        end
        @(negedge clk);
        s_axi_arvalid = 1'b0;
        n = 0;
        while (!s_axi_rvalid) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) abort_run("no read data arrived");
        end
        data = s_axi_rdata;
        check_value("s_axi_rresp", 32'(s_axi_rresp), 32'h0);
        @(negedge clk);  // rvalid and rdata held while rready low
        s_axi_rready = 1'b1;
        @(negedge clk);
        s_axi_rready = 1'b0;
    endtask

    task automatic push_source(input logic [31:0] word);
        @(negedge clk);
        source_data   = word;
        source_strobe = 1'b1;
        @(negedge clk);
        source_strobe = 1'b0;
    endtask

    task automatic drain_sink(input int cycles, input int words);
        logic [31:0] got_q[$];
        logic [31:0] exp;
        int          i;
        @(negedge clk);
        sink_ready = 1'b1;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (sink_strobe) got_q.push_back(sink_data);
        end
        sink_ready = 1'b0;
        check_value("sink word count", 32'(got_q.size()), 32'(words));
        for (i = 0; i < got_q.size(); i++) begin
            if (sent_q.size() == 0) abort_run("sink put out a word that was never written");
            exp = swap_bytes(sent_q.pop_front());
            check_value("sink_data", got_q[i], exp);
        end
    endtask

    task automatic wait_intr(input logic level);
        int n;
        n = 0;
        while (intr !== level && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        check_value("intr", 32'(intr), 32'(level));
    endtask

    task automatic run_command(input string op, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] got;
        int          i;
        if (op == "write") begin
            axi_write(a[5:0], b);
            if (a == 32'h00) sent_q.push_back(b);
            if (a == 32'h08) sent_q.delete();  // tx cleared
        end else if (op == "read") begin
            axi_read(a[5:0], got);
            check_value($sformatf("s_axi_rdata @%h", a), got, b);
        end else if (op == "push") begin
            if (b == 0) begin
                push_source(a);
            end else begin
                for (i = 0; i < b; i++) push_source($random(seed));
            end
        end else if (op == "sink") begin
            drain_sink(a, b);
        end else if (op == "irq") begin
            wait_intr(a[0]);
        end else begin
            abort_run({"unknown command in the vector file: ", op});
        end
    endtask

    initial begin
        int          fd;
        int          r;
        int          c;
        string       op;
        logic [31:0] a;
        logic [31:0] b;
        seed          = 32'h7ad484a3;
        rst           = 1'b1;
        s_axi_awaddr  = '0;
        s_axi_awprot  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = 4'hf;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arprot  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        sink_ready    = 1'b0;
        source_data   = '0;
        source_strobe = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("sim/fifo_if_vectors.txt", "r");
        if (fd == 0) abort_run("could not open sim/fifo_if_vectors.txt");
        r = $fscanf(fd, "%s", op);
        while (r == 1) begin
            if (op[0] == "#") begin
                c = $fgetc(fd);  // skip the rest of a comment line
                while (c != "\n" && c != -1) c = $fgetc(fd);
            end else begin
                if ($fscanf(fd, "%h %h", a, b) != 2) abort_run("malformed line in the vector file");
                run_command(op, a, b);
            end
            r = $fscanf(fd, "%s", op);
        end
        $fclose(fd);

        repeat (2) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- sim/fifo_if_vectors.txt
# columns: command, then two hex fields
# write addr data | read addr expected | push word nrandom | sink cycles nwords | irq level 0
read 04 00000000
read 08 00000000
read 0c 00000008
read 10 00000008
read 20 00000000
irq 0 0
write 00 11223344
read 08 00000001
write 00 a5b6c7d8
write 00 0badf00d
read 08 00000003
sink 5 3
read 08 00000000
push cafe0001 0
push cafe0002 0
read 04 00000002
read 00 cafe0001
read 04 00000001
read 00 cafe0002
read 04 00000000
push 0 12
read 04 00000010
write 04 0
read 04 00000000
write 00 00000001
write 08 0
read 08 00000000
write 20 2
irq 1 0
write 10 0
write 00 76543210
write 00 fedcba98
irq 0 0
read 24 00000000
write 0c 3
write 20 1
irq 0 0
push 0 3
irq 1 0
read 24 00000001
